// ==== logic/serial_cfg.svh ====
// build-time sizes of the 3-wire master, shared by package and modules
// half period counts in_clk cycles, so the serial clock is in_clk / (2 * half period)
// channel count must stay well below the word length, the collector relies on it
`ifndef SERIAL_CFG_SVH
`define SERIAL_CFG_SVH

// bits per serial word
`define SERIAL_BITS 8

// number of independent channels / engines
`define SERIAL_CHANNELS 4

// in_clk cycles per serial clock half period, at least 1
`define SERIAL_HALF_PERIOD 4

// 1: low bit goes out first, 0: high bit first
`define SERIAL_LOWBIT_FIRST 1

`endif

// ==== logic/serial_pkg.sv ====
// types shared by all blocks of the 3-wire master
// widths follow the macros in the cfg header
`default_nettype none

`include "serial_cfg.svh"

package serial_pkg;

	// one serial data word
	typedef logic [`SERIAL_BITS-1 : 0] t_word;

	// channel number
	typedef logic [$clog2(`SERIAL_CHANNELS)-1 : 0] t_chan;

	// engine states, idle or shifting a word
	typedef enum logic [0 : 0] {
		serial_ready    = 1'b0,
		serial_transmit = 1'b1
	} t_serial_state;

endpackage

`default_nettype wire

// ==== logic/serial_tickgen.sv ====
// shared serial clock phase generator for all channels
// strobes run freely from reset on, engines only pick the ones they need
`timescale 1ns/100ps
`default_nettype none

`include "serial_cfg.svh"

module serial_tickgen (
	input  wire  in_clk,
	input  wire  in_rst,
	output logic fall_tick,
	output logic rise_tick
);

	localparam int cnt_w = $clog2(`SERIAL_HALF_PERIOD + 1);

	// cycles within the current half period
	logic [cnt_w-1 : 0] cnt;
	// high half of the serial clock, idles high like sclk
	logic phase;
	logic wrap;

	assign wrap = cnt == cnt_w'(`SERIAL_HALF_PERIOD - 1);

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			cnt       <= '0;
			phase     <= 1'b1;
			fall_tick <= 1'b0;
			rise_tick <= 1'b0;
		end else begin
			// strobe marks entry into the new half
			fall_tick <= wrap & phase;
			rise_tick <= wrap & ~phase;
			if (wrap) begin
				cnt   <= '0;
				phase <= ~phase;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/serial_dispatch.sv ====
// one pending word per channel between host and engines
// writes to a full slot are dropped, the host has to watch free
`timescale 1ns/100ps
`default_nettype none

`include "serial_cfg.svh"

module serial_dispatch (
	input  wire                      in_clk,
	input  wire                      in_rst,
	input  wire                      wr,
	input  serial_pkg::t_chan        wr_chan,
	input  serial_pkg::t_word        wr_data,
	input  wire [`SERIAL_CHANNELS-1 : 0] take,
	output logic [`SERIAL_CHANNELS-1 : 0] free,
	output logic [`SERIAL_CHANNELS-1 : 0] enable,
	output serial_pkg::t_word        word [`SERIAL_CHANNELS]
);

	import serial_pkg::*;

	// slot holds a word
	logic [`SERIAL_CHANNELS-1 : 0] valid;
	// slot contents
	t_word slot [`SERIAL_CHANNELS];
	// accepted host write, per channel
	logic [`SERIAL_CHANNELS-1 : 0] load;

	always_comb begin
		for (int i = 0; i < `SERIAL_CHANNELS; i++) begin
			load[i] = wr & (wr_chan == t_chan'(i)) & ~valid[i];
		end
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			valid <= '0;
		end else begin
			// take and load never meet, take needs a full slot
			valid <= (valid & ~take) | load;
		end
	end

	always_ff @(posedge in_clk) begin
		for (int i = 0; i < `SERIAL_CHANNELS; i++) begin
			if (load[i]) begin
				slot[i] <= wr_data;
			end
		end
	end

	assign enable = valid;
	assign free   = ~valid;
	assign word   = slot;

endmodule

`default_nettype wire

// ==== logic/serial_engine.sv ====
// one 3-wire channel, mode with serial clock idling high
// mosi changes on falling sclk, miso is sampled on rising sclk
// sclk keeps running across words while enable is high at the word end
`timescale 1ns/100ps
`default_nettype none

`include "serial_cfg.svh"

module serial_engine (
	input  wire               in_clk,
	input  wire               in_rst,
	input  wire               fall_tick,
	input  wire               rise_tick,
	input  wire               enable,
	input  serial_pkg::t_word word,
	output logic              take,
	output logic              done,
	output serial_pkg::t_word rx_word,
	output logic              sclk,
	output logic              mosi,
	input  wire               miso
);

	import serial_pkg::*;

	localparam int ctr_w = $clog2(`SERIAL_BITS);

	t_serial_state state;
	logic [ctr_w-1 : 0] bit_ctr;
	// word being shifted out
	t_word tx_reg;
	// word being assembled from miso
	t_word rx_reg;

	// tick decode
	logic last_bit;
	logic start;
	logic finish;
	logic shift;
	logic sample;

	// counter position to word bit, per bit order
	function automatic logic [ctr_w-1 : 0] map_idx(input logic [ctr_w-1 : 0] ctr);
		if (`SERIAL_LOWBIT_FIRST == 1) begin
			return ctr;
		end
		return ctr_w'(`SERIAL_BITS - 1) - ctr;
	endfunction

	assign last_bit = (state == serial_transmit) & (bit_ctr == ctr_w'(`SERIAL_BITS - 1));

	// new word, either from idle or straight after the last bit
	assign start  = fall_tick & enable & ((state == serial_ready) | last_bit);
	assign finish = fall_tick & last_bit;
	assign shift  = fall_tick & (state == serial_transmit) & ~last_bit;
	assign sample = rise_tick & (state == serial_transmit);

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state   <= serial_ready;
			bit_ctr <= '0;
			sclk    <= 1'b1;
			mosi    <= 1'b1;
			take    <= 1'b0;
			done    <= 1'b0;
		end else begin
			take <= start;
			done <= finish;
			if (start) begin
				// first bit goes out with the falling edge
				state   <= serial_transmit;
				bit_ctr <= '0;
				sclk    <= 1'b0;
				mosi    <= word[map_idx('0)];
			end else if (finish) begin
				// nothing waiting, park lines high
				state <= serial_ready;
				sclk  <= 1'b1;
				mosi  <= 1'b1;
			end else if (shift) begin
				bit_ctr <= bit_ctr + 1'b1;
				sclk    <= 1'b0;
				mosi    <= tx_reg[map_idx(ctr_w'(bit_ctr + 1'b1))];
			end else if (sample) begin
				sclk <= 1'b1;
			end
		end
	end

	always_ff @(posedge in_clk) begin
		if (start) begin
			tx_reg <= word;
		end
		// device drives miso after falling sclk, stable here
		if (sample) begin
			rx_reg[map_idx(bit_ctr)] <= miso;
		end
		// last bit was sampled on the preceding rise
		if (finish) begin
			rx_word <= rx_reg;
		end
	end

endmodule

`default_nettype wire

// ==== logic/serial_collect.sv ====
// merges received words of all channels into one stream, lowest channel wins
// no back-pressure, one holding register per channel is enough
// since a channel finishes at most once per word time
`timescale 1ns/100ps
`default_nettype none

`include "serial_cfg.svh"

module serial_collect (
	input  wire                      in_clk,
	input  wire                      in_rst,
	input  wire [`SERIAL_CHANNELS-1 : 0] done,
	input  serial_pkg::t_word        rx_word [`SERIAL_CHANNELS],
	output logic                     rx_valid,
	output serial_pkg::t_chan        rx_chan,
	output serial_pkg::t_word        rx_data
);

	import serial_pkg::*;

	logic [`SERIAL_CHANNELS-1 : 0] pending;
	t_word hold [`SERIAL_CHANNELS];

	// a fresh done competes in the same cycle
	logic [`SERIAL_CHANNELS-1 : 0] req;
	logic  sel_hit;
	t_chan sel;
	t_word sel_data;

	assign req = pending | done;

	// priority encoder, descending loop leaves the lowest request
	always_comb begin
		sel_hit  = 1'b0;
		sel      = '0;
		sel_data = '0;
		for (int i = `SERIAL_CHANNELS - 1; i >= 0; i--) begin
			if (req[i]) begin
				sel_hit  = 1'b1;
				sel      = t_chan'(i);
				// held word is older than the one just finished
				sel_data = pending[i] ? hold[i] : rx_word[i];
			end
		end
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			pending  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= sel_hit;
			for (int i = 0; i < `SERIAL_CHANNELS; i++) begin
				if (done[i]) begin
					// bypassed straight out only if nothing older was held
					pending[i] <= ~(sel_hit & (sel == t_chan'(i)) & ~pending[i]);
				end else if (sel_hit & (sel == t_chan'(i))) begin
					pending[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge in_clk) begin
		for (int i = 0; i < `SERIAL_CHANNELS; i++) begin
			if (done[i]) begin
				hold[i] <= rx_word[i];
			end
		end
		if (sel_hit) begin
			rx_chan <= sel;
			rx_data <= sel_data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/serial_bus.sv ====
// multi-channel 3-wire master, host side writes words, reads tagged replies
// all sclk lines share one phase, idle high, no chip selects
`timescale 1ns/100ps
`default_nettype none

`include "serial_cfg.svh"

module serial_bus (
	input  wire                      in_clk,
	input  wire                      in_rst,
	input  wire                      wr,
	input  serial_pkg::t_chan        wr_chan,
	input  serial_pkg::t_word        wr_data,
	output logic [`SERIAL_CHANNELS-1 : 0] free,
	output logic                     rx_valid,
	output serial_pkg::t_chan        rx_chan,
	output serial_pkg::t_word        rx_data,
	output logic [`SERIAL_CHANNELS-1 : 0] sclk,
	output logic [`SERIAL_CHANNELS-1 : 0] mosi,
	input  wire [`SERIAL_CHANNELS-1 : 0] miso
);

	import serial_pkg::*;

	// shared serial clock phase
	logic fall_tick;
	logic rise_tick;

	// dispatch to engines
	logic [`SERIAL_CHANNELS-1 : 0] enable;
	logic [`SERIAL_CHANNELS-1 : 0] take;
	t_word word [`SERIAL_CHANNELS];

	// engines to collector
	logic [`SERIAL_CHANNELS-1 : 0] done;
	t_word rx_word [`SERIAL_CHANNELS];

	serial_tickgen u_tickgen (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.fall_tick (fall_tick),
		.rise_tick (rise_tick)
	);

	serial_dispatch u_dispatch (
		.in_clk  (in_clk),
		.in_rst  (in_rst),
		.wr      (wr),
		.wr_chan (wr_chan),
		.wr_data (wr_data),
		.take    (take),
		.free    (free),
		.enable  (enable),
		.word    (word)
	);

	// one engine per channel
	for (genvar i = 0; i < `SERIAL_CHANNELS; i++) begin : g_chan
		serial_engine u_engine (
			.in_clk    (in_clk),
			.in_rst    (in_rst),
			.fall_tick (fall_tick),
			.rise_tick (rise_tick),
			.enable    (enable[i]),
			.word      (word[i]),
			.take      (take[i]),
			.done      (done[i]),
			.rx_word   (rx_word[i]),
			.sclk      (sclk[i]),
			.mosi      (mosi[i]),
			.miso      (miso[i])
		);
	end

	serial_collect u_collect (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.done     (done),
		.rx_word  (rx_word),
		.rx_valid (rx_valid),
		.rx_chan  (rx_chan),
		.rx_data  (rx_data)
	);

endmodule

`default_nettype wire

// ==== dv/serial_device_model.sv ====
// behavioral 3-wire device, sclk idles high, mosi sampled on rising sclk
// replies with the word it received before, first reply is A0 plus the channel
// sclk edges are ignored while in_rst is high
`timescale 1ns/100ps
`default_nettype none

`include "serial_cfg.svh"

module serial_device_model (
	input  wire               in_rst,
	input  serial_pkg::t_chan chan,
	input  wire               sclk,
	input  wire               mosi,
	output logic              miso,
	output int                word_count,
	output serial_pkg::t_word last_word,
	output int                bit_pos
);

	import serial_pkg::*;

	// word rebuilt from mosi
	t_word rx_shift;
	// answer for the next word
	t_word reply;
	// answer being shifted out
	t_word tx_shift;

	// shift position to word bit
	function automatic int bit_idx(input int pos);
		return (`SERIAL_LOWBIT_FIRST == 1) ? pos : `SERIAL_BITS - 1 - pos;
	endfunction

	initial begin
		miso = 1'b1;
	end

	// first sclk edge out of x also lands here, inside reset
	always @(posedge in_rst or posedge sclk) begin
		if (in_rst) begin
			reply      = t_word'(8'hA0 + chan);
			rx_shift   = '0;
			bit_pos    = 0;
			word_count = 0;
		end else begin
			rx_shift[bit_idx(bit_pos)] = mosi;
			if (bit_pos == `SERIAL_BITS - 1) begin
				// full word, becomes the next answer
				last_word  = rx_shift;
				reply      = rx_shift;
				word_count = word_count + 1;
				bit_pos    = 0;
			end else begin
				bit_pos = bit_pos + 1;
			end
		end
	end

	// answer bits change right after falling sclk
	always @(negedge sclk) begin
		if (!in_rst) begin
			if (bit_pos == 0) begin
				tx_shift = reply;
			end
			miso <= tx_shift[bit_idx(bit_pos)];
		end
	end

endmodule

`default_nettype wire

// ==== dv/serial_bus_tb.sv ====
// testbench for the 3-wire master with one echoing device per channel
// stimulus 1 ns after rising in_clk, checks on falling in_clk
`timescale 1ns/100ps
`default_nettype none

`include "serial_cfg.svh"

module serial_bus_tb;

	import serial_pkg::*;

	localparam int n_ch  = `SERIAL_CHANNELS;
	localparam int depth = 64;
	// single, one while busy, back to back, burst on every channel
	localparam int n_words     = 4 + 1 + 6 + 6 * n_ch;
	localparam int word_cycles = `SERIAL_BITS * 2 * `SERIAL_HALF_PERIOD;
	localparam int limit_ns    = (n_words * word_cycles * 2 + 400) * 8;

	logic            in_clk;
	logic            in_rst;
	logic            wr;
	t_chan           wr_chan;
	t_word           wr_data;
	logic [n_ch-1:0] free;
	logic            rx_valid;
	t_chan           rx_chan;
	t_word           rx_data;
	logic [n_ch-1:0] sclk;
	logic [n_ch-1:0] mosi;
	wire  [n_ch-1:0] miso;

	// device side view
	int    dev_count [n_ch];
	t_word dev_word [n_ch];
	int    dev_pos [n_ch];

	// scoreboard ring buffers, per channel
	t_word mosi_exp [n_ch][depth];
	t_word rx_exp [n_ch][depth];
	int    mosi_wr [n_ch];
	int    mosi_rd [n_ch];
	int    rx_wr [n_ch];
	int    rx_rd [n_ch];
	t_word last_sent [n_ch];

	int              seen [n_ch];
	// cycles sclk has been high
	int              run_high [n_ch];
	logic [n_ch-1:0] prev_free = '1;
	int              seed;

	serial_bus u_serial_bus (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.wr       (wr),
		.wr_chan  (wr_chan),
		.wr_data  (wr_data),
		.free     (free),
		.rx_valid (rx_valid),
		.rx_chan  (rx_chan),
		.rx_data  (rx_data),
		.sclk     (sclk),
		.mosi     (mosi),
		.miso     (miso)
	);

	for (genvar i = 0; i < n_ch; i++) begin : g_dev
		serial_device_model u_dev (
			.in_rst     (in_rst),
			.chan       (t_chan'(i)),
			.sclk       (sclk[i]),
			.mosi       (mosi[i]),
			.miso       (miso[i]),
			.word_count (dev_count[i]),
			.last_word  (dev_word[i]),
			.bit_pos    (dev_pos[i])
		);
	end

	initial begin
		in_clk = 1'b0;
		forever #4 in_clk = ~in_clk;
	end

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	// watchdog, twice the word time per word plus margin
	initial begin
		#(limit_ns);
		$display("watchdog expired, traffic did not complete in time");
		stop_run();
	end

	task automatic step();
		@(posedge in_clk);
		#1;
	endtask

	// one write strobe, booked only when the slot was free
	task automatic write_word(input int c, input t_word d);
		wr      = 1'b1;
		wr_chan = t_chan'(c);
		wr_data = d;
		if (free[c]) begin
			mosi_exp[c][mosi_wr[c] % depth] = d;
			mosi_wr[c]++;
			// device answers with the word before
			rx_exp[c][rx_wr[c] % depth] = last_sent[c];
			rx_wr[c]++;
			last_sent[c] = d;
		end
		step();
		wr = 1'b0;
	endtask

	task automatic send_word(input int c, input t_word d);
		while (!free[c]) begin
			step();
		end
		write_word(c, d);
	endtask

	function automatic bit outstanding();
		for (int c = 0; c < n_ch; c++) begin
			if (mosi_wr[c] != mosi_rd[c] || rx_wr[c] != rx_rd[c]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic wait_drain();
		while (outstanding()) begin
			step();
		end
		// let the lines settle back to idle
		repeat (4 * `SERIAL_HALF_PERIOD) step();
	endtask

	task automatic check_idle();
		assert (sclk == '1) else begin
			$display("Error: sclk 0x%h expected 0x%h", sclk, {n_ch{1'b1}});
			stop_run();
		end
		assert (mosi == '1) else begin
			$display("Error: mosi 0x%h expected 0x%h", mosi, {n_ch{1'b1}});
			stop_run();
		end
		assert (free == '1) else begin
			$display("Error: free 0x%h expected 0x%h", free, {n_ch{1'b1}});
			stop_run();
		end
		assert (!rx_valid) else begin
			$display("Error: rx_valid 0x%h expected 0x0", rx_valid);
			stop_run();
		end
	endtask

	// scoreboard and sclk timing
	always @(negedge in_clk) begin
		if (!in_rst) begin
			if (rx_valid) begin
				assert (rx_wr[rx_chan] != rx_rd[rx_chan]) else begin
					$display("rx_valid reported channel %0d with no outstanding word", rx_chan);
					stop_run();
				end
				assert (rx_data == rx_exp[rx_chan][rx_rd[rx_chan] % depth]) else begin
					$display("Error: rx_data 0x%h expected 0x%h", rx_data,
						rx_exp[rx_chan][rx_rd[rx_chan] % depth]);
					stop_run();
				end
				rx_rd[rx_chan]++;
			end
			for (int c = 0; c < n_ch; c++) begin
				// device just completed a word
				if (dev_count[c] != seen[c]) begin
					assert (mosi_wr[c] != mosi_rd[c]) else begin
						$display("channel %0d sent a word that was never accepted", c);
						stop_run();
					end
					assert (dev_word[c] == mosi_exp[c][mosi_rd[c] % depth]) else begin
						$display("Error: mosi word 0x%h expected 0x%h", dev_word[c],
							mosi_exp[c][mosi_rd[c] % depth]);
						stop_run();
					end
					mosi_rd[c]++;
					seen[c]++;
				end
				if (sclk[c]) begin
					run_high[c]++;
				end else begin
					run_high[c] = 0;
				end
				// longer than a half period means idle
				if (run_high[c] > `SERIAL_HALF_PERIOD) begin
					assert (mosi[c]) else begin
						$display("Error: mosi 0x%h expected 0x1 on idle channel %0d", mosi[c], c);
						stop_run();
					end
				end
				// a fall tick just passed without a start
				if (run_high[c] == `SERIAL_HALF_PERIOD + 1) begin
					assert (dev_pos[c] == 0) else begin
						$display("sclk of channel %0d paused inside a word", c);
						stop_run();
					end
					assert (prev_free[c]) else begin
						$display("channel %0d idled its sclk while a word was waiting", c);
						stop_run();
					end
				end
			end
			prev_free = free;
		end else begin
			// sclk idle since reset, tick phase only known after the first word
			for (int c = 0; c < n_ch; c++) begin
				run_high[c] = `SERIAL_HALF_PERIOD + 1;
			end
		end
	end

	initial begin
		seed    = 75419;
		in_rst  = 1'b1;
		wr      = 1'b0;
		wr_chan = '0;
		wr_data = '0;
		for (int c = 0; c < n_ch; c++) begin
			last_sent[c] = t_word'(8'hA0 + c);
		end
		repeat (3) @(posedge in_clk);
		#1;
		in_rst = 1'b0;
		check_idle();

		// one word per channel, idle in between
		for (int c = 0; c < n_ch; c++) begin
			send_word(c, t_word'($random(seed)));
			wait_drain();
			check_idle();
		end

		// second write hits a full slot and must vanish
		send_word(1, t_word'($random(seed)));
		assert (!free[1]) else begin
			$display("free of channel 1 still high after a write");
			stop_run();
		end
		write_word(1, t_word'($random(seed)));
		wait_drain();

		// refills while busy, sclk keeps running
		repeat (6) send_word(2, t_word'($random(seed)));
		wait_drain();

		// all channels loaded together
		repeat (6) begin
			for (int c = 0; c < n_ch; c++) begin
				send_word(c, t_word'($random(seed)));
			end
		end
		wait_drain();
		check_idle();

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/serial_pkg.sv
logic/serial_tickgen.sv
logic/serial_dispatch.sv
logic/serial_engine.sv
logic/serial_collect.sv
logic/serial_bus.sv
dv/serial_device_model.sv
dv/serial_bus_tb.sv
